//--- source/mmio_pkg.sv
package mmio_pkg;

	////////////////////
	// Bus widths and sizes
	////////////////////
	localparam int DATA_W     = 16;
	localparam int ADDR_W     = 14;
	localparam int RAM_WORDS  = 11264;
	localparam int PIX_DEPTH  = 8;
	localparam int PIX_PTR_W  = $clog2(PIX_DEPTH);
	localparam int PIX_CNT_W  = $clog2(PIX_DEPTH + 1);
	localparam int NUM_KEYS   = 6;
	localparam int MMIO_TAG_W = 11;
	localparam int MMIO_OFF_W = 3;

	// Key index, register offset is NUM_KEYS minus the index
	localparam int KEY_FORWARD  = 0;
	localparam int KEY_BACKWARD = 1;
	localparam int KEY_RIGHT    = 2;
	localparam int KEY_LEFT     = 3;
	localparam int KEY_SHOOT    = 4;
	localparam int KEY_ESCAPE   = 5;

	// Register offsets inside the MMIO block at 3FF8..3FFF
	localparam logic [MMIO_OFF_W-1:0] PIX_OFFSET = 3'd7;
	localparam logic [MMIO_OFF_W-1:0] LCD_OFFSET = 3'd0;
	localparam logic [MMIO_TAG_W-1:0] MMIO_TAG   = '1;

	// PS/2 set 2 make codes
	localparam logic [7:0] SC_W     = 8'h1D;
	localparam logic [7:0] SC_S     = 8'h1B;
	localparam logic [7:0] SC_D     = 8'h23;
	localparam logic [7:0] SC_A     = 8'h1C;
	localparam logic [7:0] SC_SPACE = 8'h29;
	localparam logic [7:0] SC_ESC   = 8'h76;
	localparam logic [7:0] SC_BREAK = 8'hF0;

	////////////////////
	// Address views and bus structs
	////////////////////
	typedef struct packed {
		logic [MMIO_TAG_W-1:0] tag;
		logic [MMIO_OFF_W-1:0] offset;
	} mmio_sel_s;

	// Same 14 bits seen as a RAM word or as an MMIO select
	typedef union packed {
		logic [ADDR_W-1:0] word;
		mmio_sel_s         sel;
	} mem_addr_u;

	typedef struct packed {
		mem_addr_u         addr;
		logic [DATA_W-1:0] wdata;
		logic              we;
		logic              pad;
	} cpu_req_s;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic              we;
	} ram_wr_s;

	typedef logic [DATA_W-1:0] key_count_t;

endpackage

//--- source/key_scanner.sv
`timescale 1ns/1ns

module key_scanner import mmio_pkg::*; (
	input  logic                clk,
	input  logic                arst_n,
	input  logic [7:0]          kbd_code,
	input  logic                kbd_strobe,
	output logic [NUM_KEYS-1:0] press
);

	// Set by F0, the next code is a release
	logic break_pend;

	////////////////////
	// Break prefix tracking
	////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			break_pend <= 1'b0;
		end else if (kbd_strobe) begin
			// Any code after the prefix consumes it, even another F0
			break_pend <= !break_pend && (kbd_code == SC_BREAK);
		end
	end

	////////////////////
	// Make code decode
	////////////////////
	always_comb begin
		press = '0;
		if (kbd_strobe && !break_pend) begin
			case (kbd_code)
				SC_W: begin
					press[KEY_FORWARD] = 1'b1;
				end
				SC_S: begin
					press[KEY_BACKWARD] = 1'b1;
				end
				SC_D: begin
					press[KEY_RIGHT] = 1'b1;
				end
				SC_A: begin
					press[KEY_LEFT] = 1'b1;
				end
				SC_SPACE: begin
					press[KEY_SHOOT] = 1'b1;
				end
				SC_ESC: begin
					press[KEY_ESCAPE] = 1'b1;
				end
				default: begin
					// unknown codes and the prefix itself
					press = '0;
				end
			endcase
		end
	end

endmodule

//--- source/key_latch.sv
`timescale 1ns/1ns

module key_latch import mmio_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       press,
	input  logic       clear,
	output key_count_t count
);

	logic at_max;

	// Counter stops at all ones
	assign at_max = &count;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (clear) begin
			// CPU clear beats a press in the same cycle
			count <= '0;
		end else if (press && !at_max) begin
			count <= count + 1'b1;
		end
	end

endmodule

//--- source/data_ram.sv
`timescale 1ns/1ns

module data_ram import mmio_pkg::*; (
	input  logic              clk,
	input  ram_wr_s           ram_wr,
	input  logic [ADDR_W-1:0] ram_raddr,
	output logic [DATA_W-1:0] ram_rdata
);

	////////////////////
	// Storage
	////////////////////
	logic [DATA_W-1:0] mem [RAM_WORDS];

	// Write port, the controller only enables addresses in range
	always_ff @(posedge clk) begin
		if (ram_wr.we) begin
			mem[ram_wr.addr] <= ram_wr.data;
		end
	end

	// Read port is combinational to serve the CPU in the same cycle
	assign ram_rdata = mem[ram_raddr];

endmodule

//--- source/pixel_queue.sv
`timescale 1ns/1ns

module pixel_queue import mmio_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              push,
	input  logic [DATA_W-1:0] wdata,
	input  logic              pop,
	output logic [DATA_W-1:0] rdata,
	output logic              full,
	output logic              empty
);

	logic [DATA_W-1:0]    mem [PIX_DEPTH];
	logic [PIX_PTR_W-1:0] wr_ptr;
	logic [PIX_PTR_W-1:0] rd_ptr;
	logic [PIX_CNT_W-1:0] used;
	logic                 push_ok;
	logic                 pop_ok;

	assign full    = (used == PIX_CNT_W'(PIX_DEPTH));
	assign empty   = (used == '0);
	assign push_ok = push && !full;
	assign pop_ok  = pop && !empty;

	// Head of the queue
	assign rdata = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push_ok) begin
			mem[wr_ptr] <= wdata;
		end
	end

	////////////////////
	// Pointers and fill level
	////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used   <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= (wr_ptr == PIX_PTR_W'(PIX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= (rd_ptr == PIX_PTR_W'(PIX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leave the level alone
			if (push_ok && !pop_ok) begin
				used <= used + 1'b1;
			end else if (pop_ok && !push_ok) begin
				used <= used - 1'b1;
			end
		end
	end

endmodule

//--- source/memory_controller.sv
`timescale 1ns/1ns

module memory_controller import mmio_pkg::*; (
	input  logic                      clk,
	input  logic                      arst_n,
	input  cpu_req_s                  cpu_req,
	output logic [DATA_W-1:0]         rd_data,
	output ram_wr_s                   ram_wr,
	output logic [ADDR_W-1:0]         ram_raddr,
	input  logic [DATA_W-1:0]         ram_rdata,
	output logic                      pix_push,
	output logic [DATA_W-1:0]         pix_wdata,
	input  logic                      pix_full,
	input  key_count_t [NUM_KEYS-1:0] key_count,
	output logic [NUM_KEYS-1:0]       key_clear,
	output logic [DATA_W-1:0]         lcd_data
);

	mem_addr_u           addr;
	logic                sel_ram;
	logic                sel_pix;
	logic                sel_lcd;
	logic [NUM_KEYS-1:0] sel_key;
	logic                wr_nonzero;

	assign addr       = cpu_req.addr;
	assign wr_nonzero = |cpu_req.wdata;

	////////////////////
	// Address decode
	////////////////////
	// RAM region first, then the register block at the top of the map
	always_comb begin
		sel_ram = 1'b0;
		sel_pix = 1'b0;
		sel_lcd = 1'b0;
		sel_key = '0;
		if (addr.word < ADDR_W'(RAM_WORDS)) begin
			sel_ram = 1'b1;
		end else if (addr.sel.tag == MMIO_TAG) begin
			if (addr.sel.offset == PIX_OFFSET) begin
				sel_pix = 1'b1;
			end else if (addr.sel.offset == LCD_OFFSET) begin
				sel_lcd = 1'b1;
			end else begin
				// Forward sits at offset 6, escape at offset 1
				for (int k = 0; k < NUM_KEYS; k++) begin
					if (addr.sel.offset == MMIO_OFF_W'(NUM_KEYS - k)) begin
						sel_key[k] = 1'b1;
					end
				end
			end
		end
	end

	////////////////////
	// Write steering
	////////////////////
	// Address and data go to every target, only the selected one is enabled
	assign ram_wr.addr = addr.word;
	assign ram_wr.data = cpu_req.wdata;
	assign ram_wr.we   = cpu_req.we && sel_ram;

	assign pix_push  = cpu_req.we && sel_pix;
	assign pix_wdata = cpu_req.wdata;

	// A zero write to a key leaves its count alone
	assign key_clear = sel_key & {NUM_KEYS{cpu_req.we && wr_nonzero}};

	// LCD register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lcd_data <= '0;
		end else if (cpu_req.we && sel_lcd) begin
			lcd_data <= cpu_req.wdata;
		end
	end

	////////////////////
	// Read mux
	////////////////////
	assign ram_raddr = addr.word;

	// LCD and unmapped addresses read back as zero
	always_comb begin
		rd_data = '0;
		if (sel_ram) begin
			rd_data = ram_rdata;
		end else if (sel_pix) begin
			rd_data = {{(DATA_W - 1){1'b0}}, pix_full};
		end else begin
			for (int k = 0; k < NUM_KEYS; k++) begin
				if (sel_key[k]) begin
					rd_data = key_count[k];
				end
			end
		end
	end

endmodule

//--- source/game_io_top.sv
`timescale 1ns/1ns

module game_io_top import mmio_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  cpu_req_s          cpu_req,
	output logic [DATA_W-1:0] rd_data,
	input  logic [7:0]        kbd_code,
	input  logic              kbd_strobe,
	output logic [DATA_W-1:0] pix_data,
	output logic              pix_empty,
	input  logic              pix_pop,
	output logic [DATA_W-1:0] lcd_data
);

	logic [NUM_KEYS-1:0]       key_press;
	logic [NUM_KEYS-1:0]       key_clear;
	key_count_t [NUM_KEYS-1:0] key_count;
	ram_wr_s                   ram_wr;
	logic [ADDR_W-1:0]         ram_raddr;
	logic [DATA_W-1:0]         ram_rdata;
	logic                      pix_push;
	logic [DATA_W-1:0]         pix_wdata;
	logic                      pix_full;

	////////////////////
	// Keyboard path
	////////////////////
	key_scanner key_scanner_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.kbd_code   (kbd_code),
		.kbd_strobe (kbd_strobe),
		.press      (key_press)
	);

	// One counter per key, all identical
	for (genvar k = 0; k < NUM_KEYS; k++) begin : g_key
		key_latch key_latch_i (
			.clk    (clk),
			.arst_n (arst_n),
			.press  (key_press[k]),
			.clear  (key_clear[k]),
			.count  (key_count[k])
		);
	end

	////////////////////
	// CPU data port
	////////////////////
	memory_controller memory_controller_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.cpu_req   (cpu_req),
		.rd_data   (rd_data),
		.ram_wr    (ram_wr),
		.ram_raddr (ram_raddr),
		.ram_rdata (ram_rdata),
		.pix_push  (pix_push),
		.pix_wdata (pix_wdata),
		.pix_full  (pix_full),
		.key_count (key_count),
		.key_clear (key_clear),
		.lcd_data  (lcd_data)
	);

	data_ram data_ram_i (
		.clk       (clk),
		.ram_wr    (ram_wr),
		.ram_raddr (ram_raddr),
		.ram_rdata (ram_rdata)
	);

	// Drained by the display side
	pixel_queue pixel_queue_i (
		.clk    (clk),
		.arst_n (arst_n),
		.push   (pix_push),
		.wdata  (pix_wdata),
		.pop    (pix_pop),
		.rdata  (pix_data),
		.full   (pix_full),
		.empty  (pix_empty)
	);

endmodule

//--- bench/game_io_asserts.sv
`timescale 1ns/1ns

module game_io_asserts import mmio_pkg::*; (
	input logic                clk,
	input logic                arst_n,
	input cpu_req_s            cpu_req,
	input logic [DATA_W-1:0]   rd_data,
	input ram_wr_s             ram_wr,
	input logic                pix_push,
	input logic [NUM_KEYS-1:0] key_clear,
	input logic [DATA_W-1:0]   lcd_data
);

	// Bumped by every failing assertion
	int unsigned fail_count = 0;

	logic any_write;
	logic unmapped;
	logic lcd_write;

	assign any_write = ram_wr.we || pix_push || (|key_clear);
	// The hole between the RAM top and the register block
	assign unmapped  = (cpu_req.addr.word >= ADDR_W'(RAM_WORDS))
		&& (cpu_req.addr.sel.tag != MMIO_TAG);
	// CPU write aimed at the LCD register address
	assign lcd_write = cpu_req.we && (cpu_req.addr.word == {MMIO_TAG, LCD_OFFSET});

	////////////////////
	// Write steering
	////////////////////
	one_target: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({ram_wr.we, pix_push, key_clear}))
		else begin
			fail_count++;
			$error("more than one write target enabled in one cycle");
		end

	no_stray_write: assert property (@(posedge clk) disable iff (!arst_n)
		!cpu_req.we |-> !any_write)
		else begin
			fail_count++;
			$error("write enable raised without a CPU write");
		end

	lcd_hold: assert property (@(posedge clk) disable iff (!arst_n)
		!lcd_write |=> $stable(lcd_data))
		else begin
			fail_count++;
			$error("LCD register changed without a write to its address");
		end

	////////////////////
	// Read mux
	////////////////////
	unmapped_zero: assert property (@(posedge clk) disable iff (!arst_n)
		unmapped |-> (rd_data == '0))
		else begin
			fail_count++;
			$error("nonzero read data from an unmapped address");
		end

endmodule

//--- bench/game_io_tb.sv
`timescale 1ns/1ns

module game_io_tb import mmio_pkg::*; ();

	localparam logic [ADDR_W-1:0] PIX_ADDR = 14'h3FFF;
	localparam logic [ADDR_W-1:0] LCD_ADDR = 14'h3FF8;
	// Key codes, the prefix and one code no key uses
	localparam logic [7:0] CODE_POOL [8] = '{SC_W, SC_S, SC_D, SC_A, SC_SPACE, SC_ESC,
		SC_BREAK, 8'h5A};

	logic              clk;
	logic              arst_n;
	cpu_req_s          cpu_req;
	logic [DATA_W-1:0] rd_data;
	logic [7:0]        kbd_code;
	logic              kbd_strobe;
	logic [DATA_W-1:0] pix_data;
	logic              pix_empty;
	logic              pix_pop;
	logic [DATA_W-1:0] lcd_data;

	// Reference model state
	logic [DATA_W-1:0] ram_shadow [int];
	logic [DATA_W-1:0] pix_model [$];
	key_count_t        count_model [NUM_KEYS];
	logic              break_model;
	logic [DATA_W-1:0] lcd_model;
	logic [DATA_W-1:0] exp_rd;
	int                err_count = 0;
	int                check_count = 0;

	game_io_top game_io_top_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.cpu_req    (cpu_req),
		.rd_data    (rd_data),
		.kbd_code   (kbd_code),
		.kbd_strobe (kbd_strobe),
		.pix_data   (pix_data),
		.pix_empty  (pix_empty),
		.pix_pop    (pix_pop),
		.lcd_data   (lcd_data)
	);

	bind memory_controller game_io_asserts game_io_asserts_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.cpu_req   (cpu_req),
		.rd_data   (rd_data),
		.ram_wr    (ram_wr),
		.pix_push  (pix_push),
		.key_clear (key_clear),
		.lcd_data  (lcd_data)
	);

	always #20 clk = ~clk;

	////////////////////
	// Reference model
	////////////////////
	// Forward at 3FFE down to escape at 3FF9
	function automatic logic [ADDR_W-1:0] key_addr(input int k);
		return 14'h3FFE - ADDR_W'(k);
	endfunction

	function automatic int key_of_code(input logic [7:0] code);
		case (code)
			SC_W:     return KEY_FORWARD;
			SC_S:     return KEY_BACKWARD;
			SC_D:     return KEY_RIGHT;
			SC_A:     return KEY_LEFT;
			SC_SPACE: return KEY_SHOOT;
			SC_ESC:   return KEY_ESCAPE;
			default:  return -1;
		endcase
	endfunction

	// Expected read data is X for a RAM word never written
	function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] a);
		if (a < ADDR_W'(RAM_WORDS)) begin
			return ram_shadow.exists(int'(a)) ? ram_shadow[int'(a)] : 'x;
		end
		if (a == PIX_ADDR) begin
			return DATA_W'(pix_model.size() == PIX_DEPTH);
		end
		for (int k = 0; k < NUM_KEYS; k++) begin
			if (a == key_addr(k)) begin
				return count_model[k];
			end
		end
		return '0;
	endfunction

	task automatic model_step();
		int                press_k;
		logic              push_ok;
		logic              pop_ok;
		logic [ADDR_W-1:0] a;
		a       = cpu_req.addr.word;
		press_k = -1;
		// A prefix swallows the code after it, whatever that code is
		if (kbd_strobe) begin
			if (break_model) begin
				break_model = 1'b0;
			end else if (kbd_code == SC_BREAK) begin
				break_model = 1'b1;
			end else begin
				press_k = key_of_code(kbd_code);
			end
		end
		for (int k = 0; k < NUM_KEYS; k++) begin
			if (cpu_req.we && a == key_addr(k) && cpu_req.wdata != '0) begin
				count_model[k] = '0;
			end else if (press_k == k && count_model[k] != '1) begin
				count_model[k] = count_model[k] + 16'd1;
			end
		end
		// Legality of both queue sides comes from the level before the edge
		push_ok = cpu_req.we && a == PIX_ADDR && pix_model.size() < PIX_DEPTH;
		pop_ok  = pix_pop && pix_model.size() > 0;
		if (pop_ok) begin
			void'(pix_model.pop_front());
		end
		if (push_ok) begin
			pix_model.push_back(cpu_req.wdata);
		end
		if (cpu_req.we && a == LCD_ADDR) begin
			lcd_model = cpu_req.wdata;
		end
		if (cpu_req.we && a < ADDR_W'(RAM_WORDS)) begin
			ram_shadow[int'(a)] = cpu_req.wdata;
		end
	endtask

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pix_model.delete();
			break_model = 1'b0;
			lcd_model   = '0;
			for (int k = 0; k < NUM_KEYS; k++) begin
				count_model[k] = '0;
			end
		end else begin
			model_step();
		end
	end

	////////////////////
	// Checker
	////////////////////
	task automatic check_value(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// Outputs are settled at the falling edge
	always @(negedge clk) begin
		if (arst_n) begin
			exp_rd = ref_read(cpu_req.addr.word);
			if (!$isunknown(exp_rd)) begin
				check_value("rd_data", rd_data, exp_rd);
			end
			check_value("lcd_data", lcd_data, lcd_model);
			check_value("pix_empty", {15'd0, pix_empty}, {15'd0, pix_model.size() == 0});
			if (pix_model.size() > 0) begin
				check_value("pix_data", pix_data, pix_model[0]);
			end
		end
	end

	task automatic close_run(input string why);
		int assert_fails;
		assert_fails = game_io_top_i.memory_controller_i.game_io_asserts_i.fail_count;
		if (why != "") begin
			$display("Run stopped early: %s", why);
		end
		$display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
			check_count, err_count, assert_fails);
		if (why == "" && err_count == 0 && assert_fails == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	endtask

	////////////////////
	// Stimulus
	////////////////////
	task automatic drive_cycle(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
		input logic we, input logic strobe, input logic [7:0] code, input logic pop);
		cpu_req_s req;
		req.addr.word = a;
		req.wdata     = d;
		req.we        = we;
		req.pad       = 1'b0;
		@(posedge clk);
		cpu_req    <= req;
		kbd_strobe <= strobe;
		kbd_code   <= code;
		pix_pop    <= pop;
	endtask

	task automatic cpu_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
		drive_cycle(a, d, 1'b1, 1'b0, 8'h00, 1'b0);
	endtask

	task automatic cpu_read(input logic [ADDR_W-1:0] a);
		drive_cycle(a, '0, 1'b0, 1'b0, 8'h00, 1'b0);
	endtask

	task automatic drain_queue();
		int n = 0;
		@(negedge clk);
		while (!pix_empty && n < 2 * PIX_DEPTH) begin
			drive_cycle(PIX_ADDR, '0, 1'b0, 1'b0, 8'h00, 1'b1);
			@(negedge clk);
			n++;
		end
		if (!pix_empty) begin
			close_run("pixel queue still not empty after popping");
		end
	endtask

	initial begin
		logic [ADDR_W-1:0] a;
		logic [ADDR_W-1:0] written [$];
		logic [7:0]        code;
		int                pick;
		void'($urandom(31));
		clk        = 1'b0;
		arst_n     = 1'b0;
		cpu_req    = '0;
		kbd_code   = '0;
		kbd_strobe = 1'b0;
		pix_pop    = 1'b0;
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;

		// Registers and counts right after reset
		cpu_read(LCD_ADDR);
		cpu_read(PIX_ADDR);
		for (int k = 0; k < NUM_KEYS; k++) begin
			cpu_read(key_addr(k));
		end

		// RAM traffic with some hits in the hole above the RAM
		for (int i = 0; i < 300; i++) begin
			pick = $urandom_range(9);
			if (pick < 2) begin
				a = ADDR_W'($urandom_range(14'h3FF7, RAM_WORDS));
			end else if (pick < 5 && written.size() > 0) begin
				a = written[$urandom_range(written.size() - 1)];
			end else begin
				a = ADDR_W'($urandom_range(RAM_WORDS - 1));
			end
			if ($urandom_range(1) == 0) begin
				cpu_read(a);
			end else begin
				cpu_write(a, DATA_W'($urandom));
				if (a < ADDR_W'(RAM_WORDS)) begin
					written.push_back(a);
				end
			end
		end
		foreach (written[i]) begin
			cpu_read(written[i]);
		end

		// Scan codes while the read address walks the key registers
		for (int i = 0; i < 400; i++) begin
			code = ($urandom_range(4) == 0) ? 8'($urandom) : CODE_POOL[$urandom_range(7)];
			drive_cycle(key_addr(i % NUM_KEYS), '0, 1'b0, $urandom_range(3) != 0, code, 1'b0);
		end

		// Flush a pending prefix, give left some counts, then clear right only
		drive_cycle(key_addr(KEY_LEFT), '0, 1'b0, 1'b1, 8'h00, 1'b0);
		repeat (3) drive_cycle(key_addr(KEY_LEFT), '0, 1'b0, 1'b1, SC_A, 1'b0);
		cpu_write(key_addr(KEY_RIGHT), 16'h0040);
		cpu_write(key_addr(KEY_LEFT), '0);
		for (int k = 0; k < NUM_KEYS; k++) begin
			cpu_read(key_addr(k));
		end
		// Press and clear on the same edge
		drive_cycle(key_addr(KEY_FORWARD), 16'hFFFF, 1'b1, 1'b1, SC_W, 1'b0);
		cpu_read(key_addr(KEY_FORWARD));
		@(negedge clk);
		check_value("rd_data", rd_data, '0);

		// One push past the depth is dropped
		for (int i = 0; i <= PIX_DEPTH; i++) begin
			cpu_write(PIX_ADDR, DATA_W'($urandom));
		end
		cpu_read(PIX_ADDR);
		@(negedge clk);
		check_value("rd_data", rd_data, 16'h0001);
		drain_queue();
		for (int i = 0; i < 60; i++) begin
			drive_cycle(PIX_ADDR, DATA_W'($urandom), $urandom_range(2) != 0, 1'b0, 8'h00,
				$urandom_range(2) == 0);
		end
		drain_queue();

		cpu_write(LCD_ADDR, 16'hA5C3);
		cpu_read(LCD_ADDR);
		@(negedge clk);
		check_value("lcd_data", lcd_data, 16'hA5C3);
		check_value("rd_data", rd_data, '0);
		close_run("");
	end

endmodule

//--- vlog.f
source/mmio_pkg.sv
source/key_scanner.sv
source/key_latch.sv
source/data_ram.sv
source/pixel_queue.sv
source/memory_controller.sv
source/game_io_top.sv
bench/game_io_asserts.sv
bench/game_io_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Verilator build and run of the game I/O testbench
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module game_io_tb \
	-f vlog.f -o game_io_sim \
	|| { echo "Build failed"; exit 1; }

./obj_dir/game_io_sim +verilator+error+limit+1000 2>&1 | tee sim.log

grep -qx "SIMULATION PASSED" sim.log \
	&& { echo "Result: pass"; exit 0; } \
	|| { echo "Result: fail"; exit 1; }
